// File: filelist.f
hw/caliAcqPkg.sv
hw/sampleFifo.sv
hw/adcSerialReader.sv
hw/vaSequencer.sv
hw/framePacker.sv
hw/caliAcqTop.sv
verif/caliAcq_properties.sv
verif/caliAcqTb.sv

// File: Makefile
TOP = caliAcqTb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	  -f filelist.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: verif/caliAcqTb.sv
// Calibration acquisition testbench
// Drives calibration triggers into the top level and models the four serial
// ADCs. It rebuilds each expected frame from the drawn samples, watches the
// VA control pins and reads the output FIFO at random, including one long
// pause in reading
module caliAcqTb
  import caliAcqPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ChannelCount  = 4;
  localparam int FrameCount    = 5;
  localparam int FrameWords    = 3 + LaneCount * ChannelCount;  // Header, samples, trailer
  localparam int PressFrame    = 2;  // Frame read after a long RdEn pause
  localparam int TimeoutCycles = FrameCount * 2000 + 1000;

  logic                   Clk;
  logic                   Rst_N;
  logic                   CaliMode;
  logic                   Trig;
  logic [LaneCount-1:0]   Sdo  = '0;    // Driven by the ADC model
  logic                   RdEn = 1'b0;  // Driven by the host model
  logic                   Cnv;
  logic                   Sck;
  logic [LaneCount-1:0]   ShiftInN;
  logic                   CkbN;
  logic                   Hold;
  logic                   Dreset;
  logic                   CaliSwitch;
  logic [SampleWidth-1:0] Data;
  logic                   Empty;

  integer                 seed;
  logic [31:0]            rnd;
  int                     mismatchCount = 0;
  int                     otherCount    = 0;
  logic [SampleWidth-1:0] drawQ[$];  // Samples per conversion, lane 1 first
  logic [SampleWidth-1:0] expQ[$];   // Expected words at Data
  logic [SampleWidth-1:0] adcWord [LaneCount];
  int                     bitIdx      = -1;
  logic                   cnvDly      = 1'b0;
  logic                   holdDly     = 1'b0;
  logic                   ckbDly      = 1'b1;
  logic                   dresetDly   = 1'b1;  // Dreset is high in reset
  int                     cnvCount    = 0;
  int                     holdCount   = 0;
  int                     ckbCount    = 0;
  int                     dresetCount = 0;
  logic                   shiftSeen   = 1'b0;
  logic                   readPend    = 1'b0;
  logic                   holdOff     = 1'b0;
  int                     wordsRead   = 0;
  int                     framesRead  = 0;
  int                     idleTriggers = 0;

  caliAcqTop #(
    .ChannelCount(ChannelCount), .ShiftCycles(3), .CkbCycles(4), .HoldCycles(5),
    .SteadyCycles(6), .RecoveryCycles(8), .LaneFifoDepth(8), .OutFifoDepth(8)
  ) dut0 (
    .Clk(Clk), .Rst_N(Rst_N), .CaliMode(CaliMode), .Trig(Trig), .Sdo(Sdo), .RdEn(RdEn),
    .Cnv(Cnv), .Sck(Sck), .ShiftInN(ShiftInN), .CkbN(CkbN), .Hold(Hold), .Dreset(Dreset),
    .CaliSwitch(CaliSwitch), .Data(Data), .Empty(Empty)
  );

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      mismatchCount++;
      $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic finishRun();
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  // Header and trailer byte-swapped, then every lane in conversion order
  task automatic buildFrame();
    expQ.push_back(16'haa55);
    expQ.push_back(16'h90eb);
    for (int l = 0; l < LaneCount; l++)
    begin
      for (int c = 0; c < drawQ.size() / LaneCount; c++)
        expQ.push_back(drawQ[c * LaneCount + l]);
    end
    expQ.push_back(16'ha55a);
    drawQ.delete();
    holdCount = 0;
    ckbCount  = 0;
    shiftSeen = 1'b0;
  endtask

  task automatic pulseTrig(input int highCycles);
    @(negedge Clk);
    Trig = 1'b1;
    repeat (highCycles) @(negedge Clk);
    Trig = 1'b0;
    repeat (4) @(negedge Clk);
  endtask

  initial
  begin
    Clk = 1'b0;
    forever #20 Clk = !Clk;
  end

  initial
  begin
    repeat (TimeoutCycles) @(posedge Clk);
    otherCount++;
    $display("Error: watchdog expired after %0d cycles", TimeoutCycles);
    finishRun();
  end

  // ADC model, chip pin monitor and host reader, all on the falling edge
  always @(negedge Clk)
  begin
    if (Cnv && !cnvDly)
    begin
      cnvCount++;
      bitIdx = SampleWidth - 1;  // New conversion, MSB first
      for (int i = 0; i < LaneCount; i++)
      begin
        adcWord[i] = SampleWidth'($random(seed));
        drawQ.push_back(adcWord[i]);
      end
    end
    if (Sck && bitIdx >= 0)
    begin
      for (int i = 0; i < LaneCount; i++)
        Sdo[i] = adcWord[i][bitIdx];
      bitIdx--;
    end
    if (Hold && !holdDly)
    begin
      holdCount++;
      checkValue("CaliSwitch at Hold rise", 1, CaliSwitch);
    end
    if (!CkbN && ckbDly)
      ckbCount++;
    if (ShiftInN != '1)
      shiftSeen = 1'b1;
    if (Dreset && !dresetDly)
    begin
      dresetCount++;  // Sequence is over, check its pin history
      checkValue("Hold pulses", ChannelCount, holdCount);
      checkValue("CKB pulses", ChannelCount + 1, ckbCount);
      checkValue("ShiftInN low seen", 1, shiftSeen);
      checkValue("samples drawn", LaneCount * ChannelCount, drawQ.size());
      buildFrame();
    end
    if (readPend)
    begin
      wordsRead++;
      if (Data === 16'ha55a && wordsRead % FrameWords == 0)
        framesRead++;  // Trailer closes a frame
      if (expQ.size() == 0)
      begin
        otherCount++;
        $display("Error: word %h read while no word was expected", Data);
      end
      else
        checkValue($sformatf("frame word %0d", wordsRead), expQ.pop_front(), Data);
    end
    rnd      = $random(seed);
    RdEn     = !holdOff && rnd[0];  // About half of all cycles
    readPend = RdEn && !Empty;
    cnvDly    = Cnv;
    holdDly   = Hold;
    ckbDly    = CkbN;
    dresetDly = Dreset;
  end

  initial
  begin
    seed     = 93796;
    Rst_N    = 1'b0;
    CaliMode = 1'b0;
    Trig     = 1'b0;
    repeat (16) @(negedge Clk);
    checkValue("Dreset in reset", 1, Dreset);
    Rst_N = 1'b1;
    @(negedge Clk);
    checkValue("reset ShiftInN", 4'hf, ShiftInN);
    checkValue("reset CkbN", 1, CkbN);
    checkValue("reset Hold", 0, Hold);
    checkValue("reset CaliSwitch", 0, CaliSwitch);
    checkValue("reset Cnv", 0, Cnv);
    checkValue("reset Sck", 0, Sck);
    checkValue("reset Dreset", 0, Dreset);
    checkValue("reset Empty", 1, Empty);

    // Normal mode, triggers must not start anything
    repeat (3) pulseTrig(4);
    repeat (40) @(negedge Clk);
    checkValue("normal mode conversions", 0, cnvCount);
    checkValue("normal mode Empty", 1, Empty);

    CaliMode = 1'b1;
    for (int f = 0; f < FrameCount; f++)
    begin
      holdOff = (f == PressFrame);
      pulseTrig(3);
      idleTriggers++;
      wait (holdCount >= 2);
      pulseTrig(3);  // Busy, must be ignored
      wait (dresetCount == f + 1);
      if (f == PressFrame)
      begin
        repeat (40) @(negedge Clk);
        checkValue("output FIFO full", 1, dut0.outFull);
        holdOff = 1'b0;
      end
      wait (expQ.size() == 0 && !readPend);
      repeat (10) @(negedge Clk);
    end

    checkValue("frames built", idleTriggers, dresetCount);
    checkValue("words read", idleTriggers * FrameWords, wordsRead);
    checkValue("frames read", idleTriggers, framesRead);
    checkValue("final Empty", 1, Empty);
    finishRun();
  end

endmodule

// File: verif/caliAcq_properties.sv
// Pin-level assertions for the calibration acquisition top level
// Checks the VA control pins against each other and against the ADC pins
module caliAcqProperties
(
  input logic Clk,
  input logic Rst_N,
  input logic CkbN,
  input logic Hold,
  input logic Cnv,
  input logic Sck,
  input logic CaliSwitch,
  input logic Dreset
);

  timeunit 1ns;
  timeprecision 100ps;

  // No channel step while a sample is held
  ckbNotInHold: assert property (@(posedge Clk) disable iff (!Rst_N) !(!CkbN && Hold))
    else $error("CkbN low while Hold is high");

  // ADC activity only inside the held, injected window
  adcInHold: assert property (@(posedge Clk) disable iff (!Rst_N)
    (Cnv || Sck) |-> (Hold && CaliSwitch))
    else $error("Cnv or Sck active outside Hold and CaliSwitch");

  dresetNotInjecting: assert property (@(posedge Clk) disable iff (!Rst_N)
    !(Dreset && CaliSwitch))
    else $error("Dreset high while CaliSwitch is high");

endmodule

bind caliAcqTop caliAcqProperties props0 (
  .Clk(Clk), .Rst_N(Rst_N), .CkbN(CkbN), .Hold(Hold), .Cnv(Cnv), .Sck(Sck),
  .CaliSwitch(CaliSwitch), .Dreset(Dreset)
);

// File: hw/caliAcqTop.sv
// Calibration acquisition top level
// VA sequencer, four-lane serial ADC reader, one FIFO per lane,
// frame packer and the host-side output FIFO
module caliAcqTop
  import caliAcqPkg::*;
#(
  parameter int ChannelCount   = 32,
  parameter int ShiftCycles    = 6,
  parameter int CkbCycles      = 10,
  parameter int HoldCycles     = 90,
  parameter int SteadyCycles   = 250,
  parameter int RecoveryCycles = 4000,
  parameter int LaneFifoDepth  = 32,  // Holds a whole sequence, at least ChannelCount
  parameter int OutFifoDepth   = 64
)
(
  input  logic                   Clk,
  input  logic                   Rst_N,
  input  logic                   CaliMode,
  input  logic                   Trig,
  input  logic [LaneCount-1:0]   Sdo,
  input  logic                   RdEn,
  output logic                   Cnv,
  output logic                   Sck,
  output logic [LaneCount-1:0]   ShiftInN,
  output logic                   CkbN,
  output logic                   Hold,
  output logic                   Dreset,
  output logic                   CaliSwitch,
  output logic [SampleWidth-1:0] Data,
  output logic                   Empty
);

  logic                                  convStart;
  logic                                  sampleValid;
  logic                                  frameReady;
  logic [LaneCount-1:0][SampleWidth-1:0] laneSample;
  logic [LaneCount-1:0][SampleWidth-1:0] laneRdData;
  logic [LaneCount-1:0]                  laneRdEn;
  logic [LaneCount-1:0]                  laneEmpty;
  logic                                  outWrEn;
  logic [SampleWidth-1:0]                outWrData;
  logic                                  outFull;

  vaSequencer #(
    .ChannelCount(ChannelCount), .ShiftCycles(ShiftCycles), .CkbCycles(CkbCycles),
    .HoldCycles(HoldCycles), .SteadyCycles(SteadyCycles), .RecoveryCycles(RecoveryCycles)
  ) seq0 (
    .Clk(Clk), .Rst_N(Rst_N), .CaliMode(CaliMode), .Trig(Trig), .SampleValid(sampleValid),
    .ShiftInN(ShiftInN), .CkbN(CkbN), .Hold(Hold), .Dreset(Dreset),
    .CaliSwitch(CaliSwitch), .ConvStart(convStart), .FrameReady(frameReady)
  );

  adcSerialReader adc0 (
    .Clk(Clk), .Rst_N(Rst_N), .ConvStart(convStart), .Sdo(Sdo),
    .Cnv(Cnv), .Sck(Sck), .SampleValid(sampleValid), .LaneData(laneSample)
  );

  for (genvar i = 0; i < LaneCount; i++)
  begin : genLaneFifo
    sampleFifo #(.Depth(LaneFifoDepth)) laneFifo (
      .Clk(Clk), .Rst_N(Rst_N), .WrEn(sampleValid), .WrData(laneSample[i]),
      .RdEn(laneRdEn[i]), .RdData(laneRdData[i]), .Empty(laneEmpty[i]), .Full()
    );
  end

  framePacker pack0 (
    .Clk(Clk), .Rst_N(Rst_N), .FrameReady(frameReady), .LaneEmpty(laneEmpty),
    .LaneData(laneRdData), .OutFull(outFull), .LaneRdEn(laneRdEn),
    .OutWrEn(outWrEn), .OutWrData(outWrData)
  );

  sampleFifo #(.Depth(OutFifoDepth)) outFifo (
    .Clk(Clk), .Rst_N(Rst_N), .WrEn(outWrEn), .WrData(outWrData),
    .RdEn(RdEn), .RdData(Data), .Empty(Empty), .Full(outFull)
  );

endmodule

// File: hw/framePacker.sv
// Frame packer
// On FrameReady writes two header words, then drains lane FIFOs 1 to 4
// in order, then writes the trailer. Markers go out byte-swapped.
// Lane words are written one cycle after their read strobe; a word
// waiting on a full output FIFO is held until there is room
module framePacker
  import caliAcqPkg::*;
(
  input  logic                                  Clk,
  input  logic                                  Rst_N,
  input  logic                                  FrameReady,
  input  logic [LaneCount-1:0]                  LaneEmpty,
  input  logic [LaneCount-1:0][SampleWidth-1:0] LaneData,
  input  logic                                  OutFull,
  output logic [LaneCount-1:0]                  LaneRdEn,
  output logic                                  OutWrEn,
  output logic [SampleWidth-1:0]                OutWrData
);

  localparam int LaneIdxWidth = (LaneCount > 1) ? $clog2(LaneCount) : 1;

  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StHead0 = 2'd1;
  localparam logic [1:0] StHead1 = 2'd2;
  localparam logic [1:0] StDrain = 2'd3;

  logic [1:0]              state;
  logic                    advance;
  logic                    anyLane;
  logic [LaneIdxWidth-1:0] nextLane;
  logic                    wrPend;
  logic                    wrFromLane;
  logic [LaneIdxWidth-1:0] wrLane;
  logic [SampleWidth-1:0]  wrMarker;

  function automatic logic [SampleWidth-1:0] swapBytes(input logic [SampleWidth-1:0] w);
    return {w[SampleWidth/2-1:0], w[SampleWidth-1:SampleWidth/2]};
  endfunction

  assign advance   = !OutFull;  // Any pending word is taken this cycle
  assign OutWrEn   = wrPend && !OutFull;
  assign OutWrData = wrFromLane ? LaneData[wrLane] : wrMarker;

  // Lowest-numbered lane that still holds samples
  always_comb
  begin
    anyLane  = 1'b0;
    nextLane = '0;
    for (int i = LaneCount - 1; i >= 0; i--)
    begin
      if (!LaneEmpty[i])
      begin
        anyLane  = 1'b1;
        nextLane = LaneIdxWidth'(i);
      end
    end
  end

  always_comb
  begin
    LaneRdEn = '0;
    if (state == StDrain && advance && anyLane)
      LaneRdEn[nextLane] = 1'b1;
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      state      <= StIdle;
      wrPend     <= 1'b0;
      wrFromLane <= 1'b0;
      wrLane     <= '0;
    end
    else
    begin
      if (advance)
        wrPend <= 1'b0;
      case (state)
        StIdle:  if (FrameReady) state <= StHead0;
        StHead0:
        begin
          if (advance)
          begin
            wrPend     <= 1'b1;
            wrFromLane <= 1'b0;
            state      <= StHead1;
          end
        end
        StHead1:
        begin
          if (advance)
          begin
            wrPend     <= 1'b1;
            wrFromLane <= 1'b0;
            state      <= StDrain;
          end
        end
        StDrain:
        begin
          if (advance)
          begin
            wrPend <= 1'b1;
            if (anyLane)
            begin
              wrFromLane <= 1'b1;  // Lane word arrives next cycle
              wrLane     <= nextLane;
            end
            else
            begin
              wrFromLane <= 1'b0;  // All lanes drained, close with trailer
              state      <= StIdle;
            end
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  always_ff @(posedge Clk)
  begin
    if (advance)
    begin
      case (state)
        StHead0: wrMarker <= swapBytes(HeaderWord0);
        StHead1: wrMarker <= swapBytes(HeaderWord1);
        StDrain: wrMarker <= swapBytes(TrailerWord);
        default: wrMarker <= wrMarker;
      endcase
    end
  end

endmodule

// File: hw/vaSequencer.sv
// VA chip calibration sequencer
// On a trigger edge in calibration mode it shifts the channel pointer in,
// then per channel clocks CKB, injects charge, asserts Hold, starts one
// ADC conversion and waits for recovery. Ends with a Dreset pulse and
// a FrameReady strobe for the packer
module vaSequencer
  import caliAcqPkg::*;
#(
  parameter int ChannelCount   = 32,
  parameter int ShiftCycles    = 6,
  parameter int CkbCycles      = 10,
  parameter int HoldCycles     = 90,
  parameter int SteadyCycles   = 250,
  parameter int RecoveryCycles = 4000
)
(
  input  logic                 Clk,
  input  logic                 Rst_N,
  input  logic                 CaliMode,
  input  logic                 Trig,
  input  logic                 SampleValid,
  output logic [LaneCount-1:0] ShiftInN,
  output logic                 CkbN,
  output logic                 Hold,
  output logic                 Dreset,
  output logic                 CaliSwitch,
  output logic                 ConvStart,
  output logic                 FrameReady
);

  localparam logic [3:0] StIdle      = 4'd0;
  localparam logic [3:0] StStart     = 4'd1;
  localparam logic [3:0] StShift     = 4'd2;
  localparam logic [3:0] StCkb       = 4'd3;
  localparam logic [3:0] StCharge    = 4'd4;
  localparam logic [3:0] StHoldDelay = 4'd5;
  localparam logic [3:0] StSettle    = 4'd6;
  localparam logic [3:0] StConvert   = 4'd7;
  localparam logic [3:0] StWaitAcq   = 4'd8;
  localparam logic [3:0] StRecovery  = 4'd9;
  localparam logic [3:0] StDreset    = 4'd10;

  localparam int ChanWidth = $clog2(ChannelCount + 1);

  logic [3:0]                 state;
  logic [3:0]                 stateNext;
  logic                       trigSync1;
  logic                       trigSync2;
  logic                       trigDly;
  logic                       trigRise;
  logic [CycleCountWidth-1:0] delayCnt;
  logic [CycleCountWidth-1:0] delayLimit;
  logic                       delayDone;
  logic [ChanWidth-1:0]       chanCnt;

  assign trigRise  = trigSync2 && !trigDly;
  assign delayDone = (delayCnt == delayLimit);

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      trigSync1 <= 1'b0;
      trigSync2 <= 1'b0;
      trigDly   <= 1'b0;
    end
    else
    begin
      trigSync1 <= Trig;       // Trig is asynchronous to Clk
      trigSync2 <= trigSync1;
      trigDly   <= trigSync2;  // Edge detect
    end
  end

  // Last count value of each timed state
  always_comb
  begin
    case (state)
      StShift:     delayLimit = CycleCountWidth'(ShiftCycles - 1);
      StCkb:       delayLimit = CycleCountWidth'(CkbCycles - 1);
      StHoldDelay: delayLimit = CycleCountWidth'(HoldCycles - 1);
      StSettle:    delayLimit = CycleCountWidth'(SteadyCycles - 1);
      StRecovery:  delayLimit = CycleCountWidth'(RecoveryCycles - 1);
      default:     delayLimit = '0;
    endcase
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      StIdle:      if (CaliMode && trigRise) stateNext = StStart;
      StStart:     stateNext = StShift;
      StShift:     if (delayDone) stateNext = StCkb;
      StCkb:
      begin
        if (delayDone)
          stateNext = (chanCnt == ChanWidth'(ChannelCount)) ? StDreset : StCharge;
      end
      StCharge:    stateNext = StHoldDelay;
      StHoldDelay: if (delayDone) stateNext = StSettle;
      StSettle:    if (delayDone) stateNext = StConvert;
      StConvert:   stateNext = StWaitAcq;
      StWaitAcq:   if (SampleValid) stateNext = StRecovery;  // Readout done
      StRecovery:  if (delayDone) stateNext = StCkb;
      StDreset:    stateNext = StIdle;
      default:     stateNext = StIdle;
    endcase
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      state    <= StIdle;
      delayCnt <= '0;
      chanCnt  <= '0;
    end
    else
    begin
      state    <= stateNext;
      delayCnt <= (stateNext != state) ? '0 : delayCnt + 1'b1;  // Restart per state
      if (state == StStart)
        chanCnt <= '0;
      else if (state == StWaitAcq && SampleValid)
        chanCnt <= chanCnt + 1'b1;  // One conversion per channel
    end
  end

  // Pins are registered from the next state so they change with the state
  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      ShiftInN   <= '1;
      CkbN       <= 1'b1;
      Hold       <= 1'b0;
      Dreset     <= 1'b1;
      CaliSwitch <= 1'b0;
      ConvStart  <= 1'b0;
      FrameReady <= 1'b0;
    end
    else
    begin
      // Shift-in stays low through the first CKB to load the pointer
      ShiftInN   <= (stateNext == StShift || (stateNext == StCkb && chanCnt == '0)) ? '0 : '1;
      CkbN       <= (stateNext != StCkb);
      Hold       <= (stateNext inside {StSettle, StConvert, StWaitAcq});
      Dreset     <= (stateNext == StDreset);
      CaliSwitch <= (stateNext inside {StCharge, StHoldDelay, StSettle, StConvert, StWaitAcq});
      ConvStart  <= (stateNext == StConvert);
      FrameReady <= (state == StDreset);  // On the return to idle
    end
  end

endmodule

// File: hw/adcSerialReader.sv
// Four-lane serial ADC reader
// Drives the shared Cnv and Sck pins for one conversion per ConvStart
// and shifts the four Sdo lanes in parallel, MSB first
module adcSerialReader
  import caliAcqPkg::*;
(
  input  logic                                  Clk,
  input  logic                                  Rst_N,
  input  logic                                  ConvStart,
  input  logic [LaneCount-1:0]                  Sdo,
  output logic                                  Cnv,
  output logic                                  Sck,
  output logic                                  SampleValid,
  output logic [LaneCount-1:0][SampleWidth-1:0] LaneData
);

  localparam int CnvCycles = 8;
  localparam int CntWidth  = $clog2(SampleWidth);

  localparam logic [1:0] PhIdle  = 2'd0;
  localparam logic [1:0] PhConv  = 2'd1;
  localparam logic [1:0] PhClock = 2'd2;

  logic [1:0]          phase;
  logic [CntWidth-1:0] cnt;
  logic                shiftEn;

  // Sample at the edge that ends a high Sck phase
  assign shiftEn = (phase == PhClock) && Sck;

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      phase       <= PhIdle;
      cnt         <= '0;
      Cnv         <= 1'b0;
      Sck         <= 1'b0;
      SampleValid <= 1'b0;
    end
    else
    begin
      SampleValid <= 1'b0;
      case (phase)
        PhIdle:
        begin
          if (ConvStart)
          begin
            Cnv   <= 1'b1;
            cnt   <= '0;
            phase <= PhConv;
          end
        end
        PhConv:
        begin
          if (cnt == CntWidth'(CnvCycles - 1))
          begin
            Cnv   <= 1'b0;  // Conversion time elapsed
            cnt   <= '0;
            phase <= PhClock;
          end
          else
            cnt <= cnt + 1'b1;
        end
        PhClock:
        begin
          Sck <= !Sck;
          if (Sck)
          begin
            if (cnt == CntWidth'(SampleWidth - 1))
            begin
              SampleValid <= 1'b1;  // Last bit in
              phase       <= PhIdle;
            end
            else
              cnt <= cnt + 1'b1;
          end
        end
        default: phase <= PhIdle;
      endcase
    end
  end

  always_ff @(posedge Clk)
  begin
    if (shiftEn)
    begin
      for (int i = 0; i < LaneCount; i++)
        LaneData[i] <= {LaneData[i][SampleWidth-2:0], Sdo[i]};
    end
  end

endmodule

// File: hw/sampleFifo.sv
// Synchronous sample FIFO
// Circular buffer with an occupancy count and a registered read port.
// A read while not empty shows the word on RdData in the next cycle
module sampleFifo
  import caliAcqPkg::*;
#(
  parameter int Depth = 32
)
(
  input  logic                   Clk,
  input  logic                   Rst_N,
  input  logic                   WrEn,
  input  logic [SampleWidth-1:0] WrData,
  input  logic                   RdEn,
  output logic [SampleWidth-1:0] RdData,
  output logic                   Empty,
  output logic                   Full
);

  localparam int AddrWidth  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountWidth = $clog2(Depth + 1);

  logic [SampleWidth-1:0] mem [Depth];
  logic [AddrWidth-1:0]   wrPtr;
  logic [AddrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0]  count;
  logic                   wrOk;
  logic                   rdOk;

  assign Empty = (count == '0);
  assign Full  = (count == CountWidth'(Depth));
  assign wrOk  = WrEn && !Full;   // Write when full is dropped
  assign rdOk  = RdEn && !Empty;

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrOk)
        wrPtr <= (wrPtr == AddrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (rdOk)
        rdPtr <= (rdPtr == AddrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      if (wrOk && !rdOk)
        count <= count + 1'b1;
      else if (rdOk && !wrOk)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge Clk)
  begin
    if (wrOk)
      mem[wrPtr] <= WrData;
    if (rdOk)
      RdData <= mem[rdPtr];
  end

endmodule

// File: hw/caliAcqPkg.sv
// Calibration acquisition shared definitions
// Sample and word widths, ADC lane count, sequencer counter width
// and the frame marker words used by the frame packer
package caliAcqPkg;

  // Bits per ADC sample and per output FIFO word
  localparam int SampleWidth = 16;

  // Number of serial ADCs, lane FIFOs and ShiftInN pins
  localparam int LaneCount = 4;

  // Width of the sequencer delay counters
  localparam int CycleCountWidth = 12;

  // Frame markers, emitted byte-swapped by the packer
  localparam logic [SampleWidth-1:0] HeaderWord0 = 16'h55aa;  // First header word
  localparam logic [SampleWidth-1:0] HeaderWord1 = 16'heb90;  // Second header word
  localparam logic [SampleWidth-1:0] TrailerWord = 16'h5aa5;  // Closes the frame

endpackage
